// ==== source/exu_op_pkg.sv ====
package exu_op_pkg;

  localparam int XLEN = 32;

  // One shift-add or restoring step per cycle
  localparam int STEPS = 32;

  typedef enum logic [4:0] {
    OP_ADD,
    OP_SUB,
    OP_SLL,
    OP_SLT,
    OP_SLTU,
    OP_XOR,
    OP_SRL,
    OP_SRA,
    OP_OR,
    OP_AND,
    OP_MUL,
    OP_MULH,
    OP_MULHSU,
    OP_MULHU,
    OP_DIV,
    OP_DIVU,
    OP_REM,
    OP_REMU
  } op_e;

  typedef enum logic [1:0] {
    UNIT_ALU,
    UNIT_MUL,
    UNIT_DIV
  } unit_e;

  // Executing unit for an operation
  function automatic unit_e unit_of(op_e op);
    case (op)
      OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU: return UNIT_MUL;
      OP_DIV, OP_DIVU, OP_REM, OP_REMU:     return UNIT_DIV;
      default:                              return UNIT_ALU;
    endcase
  endfunction

endpackage

// ==== source/exu_bus_pkg.sv ====
package exu_bus_pkg;

  // Decoded instruction entering the stage
  typedef struct packed {
    logic [exu_op_pkg::XLEN-1:0] pc;
    exu_op_pkg::op_e             op;
    logic [exu_op_pkg::XLEN-1:0] a;
    logic [exu_op_pkg::XLEN-1:0] b;
    logic [4:0]                  rd;
  } issue_t;

  // Finished result on its way to writeback
  typedef struct packed {
    logic [exu_op_pkg::XLEN-1:0] pc;
    logic [4:0]                  rd;
    logic [exu_op_pkg::XLEN-1:0] data;
  } result_t;

endpackage

// ==== source/exu_issue.sv ====
`timescale 1ns/1ps

module exu_issue (
  input  logic                clock,
  input  logic                reset,
  input  logic                flush,
  input  logic                in_valid,
  output logic                in_ready,
  input  exu_bus_pkg::issue_t in_item,
  input  logic                take,
  output logic                held_valid,
  output exu_bus_pkg::issue_t held,
  output logic                mul_start,
  output logic                div_start
);

  logic              accept;
  logic              fresh;
  exu_op_pkg::unit_e unit;

  // Refill in the same cycle the held item moves on
  assign in_ready = ~flush & (~held_valid | take);
  assign accept = in_valid & in_ready;

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      held_valid <= 1'b0;
      fresh <= 1'b0;
    end else begin
      fresh <= accept;
      if (accept) begin
        held_valid <= 1'b1;
      end else if (take) begin
        held_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      held <= in_item;
    end
  end

  assign unit = exu_op_pkg::unit_of(held.op);

  // Single kick in the first held cycle
  assign mul_start = fresh & (unit == exu_op_pkg::UNIT_MUL);
  assign div_start = fresh & (unit == exu_op_pkg::UNIT_DIV);

endmodule

// ==== source/exu_alu.sv ====
`timescale 1ns/1ps

module exu_alu (
  input  exu_op_pkg::op_e             op,
  input  logic [exu_op_pkg::XLEN-1:0] a,
  input  logic [exu_op_pkg::XLEN-1:0] b,
  output logic [exu_op_pkg::XLEN-1:0] result
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt = b[4:0];
  assign lt_signed = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      exu_op_pkg::OP_ADD:  result = a + b;
      exu_op_pkg::OP_SUB:  result = a - b;
      exu_op_pkg::OP_SLL:  result = a << shamt;
      exu_op_pkg::OP_SLT:  result = {{(exu_op_pkg::XLEN-1){1'b0}}, lt_signed};
      exu_op_pkg::OP_SLTU: result = {{(exu_op_pkg::XLEN-1){1'b0}}, lt_unsigned};
      exu_op_pkg::OP_XOR:  result = a ^ b;
      exu_op_pkg::OP_SRL:  result = a >> shamt;
      exu_op_pkg::OP_SRA:  result = $signed(a) >>> shamt;
      exu_op_pkg::OP_OR:   result = a | b;
      exu_op_pkg::OP_AND:  result = a & b;
      // M-extension ops never read this path
      default:             result = '0;
    endcase
  end

endmodule

// ==== source/exu_mul.sv ====
`timescale 1ns/1ps

module exu_mul (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        flush,
  input  logic                        start,
  input  exu_op_pkg::op_e             op,
  input  logic [exu_op_pkg::XLEN-1:0] a,
  input  logic [exu_op_pkg::XLEN-1:0] b,
  output logic                        done,
  output logic [exu_op_pkg::XLEN-1:0] product
);

  logic                                a_neg;
  logic                                b_neg;
  logic [exu_op_pkg::XLEN-1:0]         a_mag;
  logic [exu_op_pkg::XLEN-1:0]         b_mag;
  logic                                busy;
  logic [$clog2(exu_op_pkg::STEPS)-1:0] count;
  logic                                last_step;
  logic                                negate;
  logic                                high_half;
  logic [exu_op_pkg::XLEN-1:0]         mcand;
  logic [2*exu_op_pkg::XLEN-1:0]       acc;
  logic [exu_op_pkg::XLEN:0]           sum;
  logic [2*exu_op_pkg::XLEN-1:0]       acc_next;
  logic [2*exu_op_pkg::XLEN-1:0]       full;

  // MULH treats both operands as signed, MULHSU only a
  assign a_neg = ((op == exu_op_pkg::OP_MULH) || (op == exu_op_pkg::OP_MULHSU))
                 & a[exu_op_pkg::XLEN-1];
  assign b_neg = (op == exu_op_pkg::OP_MULH) & b[exu_op_pkg::XLEN-1];
  assign a_mag = a_neg ? -a : a;
  assign b_mag = b_neg ? -b : b;

  // Upper half accumulates, multiplier bits shift out the bottom
  assign sum = {1'b0, acc[2*exu_op_pkg::XLEN-1:exu_op_pkg::XLEN]}
               + (acc[0] ? {1'b0, mcand} : '0);
  assign acc_next = {sum, acc[exu_op_pkg::XLEN-1:1]};
  assign full = negate ? -acc_next : acc_next;
  assign last_step = (count == $bits(count)'(exu_op_pkg::STEPS - 1));

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      busy <= 1'b0;
      done <= 1'b0;
      count <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        count <= '0;
      end else if (busy) begin
        count <= count + 1'b1;
        if (last_step) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      acc <= {{exu_op_pkg::XLEN{1'b0}}, b_mag};
      mcand <= a_mag;
      negate <= a_neg ^ b_neg;
      high_half <= (op != exu_op_pkg::OP_MUL);
    end else if (busy) begin
      acc <= acc_next;
      if (last_step) begin
        product <= high_half ? full[2*exu_op_pkg::XLEN-1:exu_op_pkg::XLEN]
                             : full[exu_op_pkg::XLEN-1:0];
      end
    end
  end

endmodule

// ==== source/exu_div.sv ====
`timescale 1ns/1ps

module exu_div (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        flush,
  input  logic                        start,
  input  exu_op_pkg::op_e             op,
  input  logic [exu_op_pkg::XLEN-1:0] a,
  input  logic [exu_op_pkg::XLEN-1:0] b,
  output logic                        done,
  output logic [exu_op_pkg::XLEN-1:0] result
);

  logic                                 is_signed;
  logic                                 a_neg;
  logic                                 b_neg;
  logic [exu_op_pkg::XLEN-1:0]          a_mag;
  logic [exu_op_pkg::XLEN-1:0]          b_mag;
  logic                                 busy;
  logic [$clog2(exu_op_pkg::STEPS)-1:0] count;
  logic                                 last_step;
  logic                                 q_neg;
  logic                                 r_neg;
  logic                                 rem_sel;
  logic [exu_op_pkg::XLEN-1:0]          dsor;
  logic [exu_op_pkg::XLEN-1:0]          quo;
  logic [exu_op_pkg::XLEN-1:0]          rem;
  logic [exu_op_pkg::XLEN:0]            rem_shift;
  logic [exu_op_pkg::XLEN+1:0]          diff;
  logic                                 fits;
  logic [exu_op_pkg::XLEN-1:0]          rem_next;
  logic [exu_op_pkg::XLEN-1:0]          quo_next;

  assign is_signed = (op == exu_op_pkg::OP_DIV) || (op == exu_op_pkg::OP_REM);
  assign a_neg = is_signed & a[exu_op_pkg::XLEN-1];
  assign b_neg = is_signed & b[exu_op_pkg::XLEN-1];
  assign a_mag = a_neg ? -a : a;
  assign b_mag = b_neg ? -b : b;

  // Dividend bits shift from quo into the partial remainder
  assign rem_shift = {rem, quo[exu_op_pkg::XLEN-1]};
  assign diff = {1'b0, rem_shift} - {2'b00, dsor};
  assign fits = ~diff[exu_op_pkg::XLEN+1];
  assign rem_next = fits ? diff[exu_op_pkg::XLEN-1:0] : rem_shift[exu_op_pkg::XLEN-1:0];
  assign quo_next = {quo[exu_op_pkg::XLEN-2:0], fits};
  assign last_step = (count == $bits(count)'(exu_op_pkg::STEPS - 1));

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      busy <= 1'b0;
      done <= 1'b0;
      count <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        count <= '0;
      end else if (busy) begin
        count <= count + 1'b1;
        if (last_step) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      quo <= a_mag;
      rem <= '0;
      dsor <= b_mag;
      // Quotient keeps the all-ones pattern when b is zero
      q_neg <= (a_neg ^ b_neg) & (b != '0);
      // Remainder sign follows the dividend in every case
      r_neg <= a_neg;
      rem_sel <= (op == exu_op_pkg::OP_REM) || (op == exu_op_pkg::OP_REMU);
    end else if (busy) begin
      quo <= quo_next;
      rem <= rem_next;
      // MIN / -1 needs no sign fix and gives MIN with rem 0
      if (last_step) begin
        if (rem_sel) begin
          result <= r_neg ? -rem_next : rem_next;
        end else begin
          result <= q_neg ? -quo_next : quo_next;
        end
      end
    end
  end

endmodule

// ==== source/exu_writeback.sv ====
`timescale 1ns/1ps

module exu_writeback (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        flush,
  input  logic                        held_valid,
  input  exu_bus_pkg::issue_t         held,
  input  logic [exu_op_pkg::XLEN-1:0] alu_result,
  input  logic                        mul_done,
  input  logic [exu_op_pkg::XLEN-1:0] mul_result,
  input  logic                        div_done,
  input  logic [exu_op_pkg::XLEN-1:0] div_result,
  output logic                        take,
  output logic                        out_valid,
  input  logic                        out_ready,
  output exu_bus_pkg::result_t        out_item
);

  exu_op_pkg::unit_e           unit;
  logic                        mul_flag;
  logic                        div_flag;
  logic                        result_ready;
  logic                        slot_free;
  logic [exu_op_pkg::XLEN-1:0] data;

  assign unit = exu_op_pkg::unit_of(held.op);

  always_comb begin
    case (unit)
      exu_op_pkg::UNIT_MUL: begin
        result_ready = mul_done | mul_flag;
        data = mul_result;
      end
      exu_op_pkg::UNIT_DIV: begin
        result_ready = div_done | div_flag;
        data = div_result;
      end
      default: begin
        result_ready = 1'b1;
        data = alu_result;
      end
    endcase
  end

  assign slot_free = ~out_valid | out_ready;
  assign take = ~flush & held_valid & result_ready & slot_free;

  // Remember a done pulse that arrived while the output was stalled
  always_ff @(posedge clock) begin
    if (reset || flush || take) begin
      mul_flag <= 1'b0;
      div_flag <= 1'b0;
    end else begin
      mul_flag <= mul_flag | mul_done;
      div_flag <= div_flag | div_done;
    end
  end

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      out_valid <= 1'b0;
    end else if (take) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      out_item <= '{pc: held.pc, rd: held.rd, data: data};
    end
  end

endmodule

// ==== source/exu_top.sv ====
`timescale 1ns/1ps

module exu_top (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 flush,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  exu_bus_pkg::issue_t  in_item,
  output logic                 out_valid,
  input  logic                 out_ready,
  output exu_bus_pkg::result_t out_item
);

  logic                        held_valid;
  exu_bus_pkg::issue_t         held;
  logic                        take;
  logic                        mul_start;
  logic                        div_start;
  logic [exu_op_pkg::XLEN-1:0] alu_result;
  logic                        mul_done;
  logic [exu_op_pkg::XLEN-1:0] mul_result;
  logic                        div_done;
  logic [exu_op_pkg::XLEN-1:0] div_result;

  exu_issue u_issue (
    .clock(clock), .reset(reset), .flush(flush),
    .in_valid(in_valid), .in_ready(in_ready), .in_item(in_item),
    .take(take), .held_valid(held_valid), .held(held),
    .mul_start(mul_start), .div_start(div_start)
  );

  exu_alu u_alu (.op(held.op), .a(held.a), .b(held.b), .result(alu_result));

  exu_mul u_mul (
    .clock(clock), .reset(reset), .flush(flush), .start(mul_start),
    .op(held.op), .a(held.a), .b(held.b), .done(mul_done), .product(mul_result)
  );

  exu_div u_div (
    .clock(clock), .reset(reset), .flush(flush), .start(div_start),
    .op(held.op), .a(held.a), .b(held.b), .done(div_done), .result(div_result)
  );

  exu_writeback u_writeback (
    .clock(clock), .reset(reset), .flush(flush),
    .held_valid(held_valid), .held(held), .alu_result(alu_result),
    .mul_done(mul_done), .mul_result(mul_result),
    .div_done(div_done), .div_result(div_result), .take(take),
    .out_valid(out_valid), .out_ready(out_ready), .out_item(out_item)
  );

endmodule

// ==== test/exu_checker.sv ====
`timescale 1ns/1ps

module exu_checker (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 flush,
  input  logic                 in_valid,
  input  logic                 in_ready,
  input  exu_bus_pkg::issue_t  in_item,
  input  logic                 out_valid,
  input  logic                 out_ready,
  input  exu_bus_pkg::result_t out_item,
  output int                   errors,
  output int                   pending,
  output int                   checked
);

  exu_bus_pkg::issue_t  expect_q[$];
  exu_bus_pkg::issue_t  head;
  exu_bus_pkg::result_t last_item;
  logic                 stalled = 1'b0;
  logic                 idle_since_reset = 1'b0;
  logic [31:0]          want;
  int                   err_count = 0;
  int                   done_count = 0;
  int                   q_size = 0;

  assign errors = err_count;
  assign pending = q_size;
  assign checked = done_count;

  // RV32IM result of one operation
  function automatic logic [31:0] expected_result(exu_op_pkg::op_e op, logic [31:0] a,
                                                  logic [31:0] b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic [63:0]        wide;
    sa = a;
    sb = b;
    case (op)
      exu_op_pkg::OP_ADD:  return a + b;
      exu_op_pkg::OP_SUB:  return a - b;
      exu_op_pkg::OP_SLL:  return a << b[4:0];
      exu_op_pkg::OP_SLT:  return {31'b0, sa < sb};
      exu_op_pkg::OP_SLTU: return {31'b0, a < b};
      exu_op_pkg::OP_XOR:  return a ^ b;
      exu_op_pkg::OP_SRL:  return a >> b[4:0];
      exu_op_pkg::OP_SRA:  return sa >>> b[4:0];
      exu_op_pkg::OP_OR:   return a | b;
      exu_op_pkg::OP_AND:  return a & b;
      exu_op_pkg::OP_MUL:  return a * b;
      exu_op_pkg::OP_MULH: begin
        wide = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        return wide[63:32];
      end
      exu_op_pkg::OP_MULHSU: begin
        wide = {{32{a[31]}}, a} * {32'b0, b};
        return wide[63:32];
      end
      exu_op_pkg::OP_MULHU: begin
        wide = {32'b0, a} * {32'b0, b};
        return wide[63:32];
      end
      exu_op_pkg::OP_DIV: begin
        if (b == 32'h0) return 32'hffff_ffff;
        if (a == 32'h8000_0000 && b == 32'hffff_ffff) return a;
        return sa / sb;
      end
      exu_op_pkg::OP_DIVU: begin
        if (b == 32'h0) return 32'hffff_ffff;
        return a / b;
      end
      exu_op_pkg::OP_REM: begin
        if (b == 32'h0) return a;
        if (a == 32'h8000_0000 && b == 32'hffff_ffff) return 32'h0;
        return sa % sb;
      end
      exu_op_pkg::OP_REMU: begin
        if (b == 32'h0) return a;
        return a % b;
      end
      default: return 32'h0;
    endcase
  endfunction

  always @(posedge clock) begin
    if (idle_since_reset && out_valid !== 1'b0) begin
      $display("CHECK FAILED out_valid: expected %h got %h", 1'b0, out_valid);
      err_count++;
    end
    if (flush && in_ready !== 1'b0) begin
      $display("CHECK FAILED in_ready: expected %h got %h", 1'b0, in_ready);
      err_count++;
    end
    // Output must hold across a stalled edge
    if (stalled && out_valid !== 1'b1) begin
      $display("Output valid dropped while the output was stalled");
      err_count++;
    end else if (stalled && out_item !== last_item) begin
      $display("CHECK FAILED out_item: expected %h got %h", last_item, out_item);
      err_count++;
    end
    if (reset || flush) begin
      expect_q.delete();
      stalled = 1'b0;
    end else begin
      if (out_valid && out_ready) begin
        if (expect_q.size() == 0) begin
          $display("Output transfer with no accepted item waiting for it");
          err_count++;
        end else begin
          head = expect_q.pop_front();
          want = expected_result(head.op, head.a, head.b);
          if (out_item.pc !== head.pc) begin
            $display("CHECK FAILED out_item.pc: expected %h got %h", head.pc, out_item.pc);
            err_count++;
          end
          if (out_item.rd !== head.rd) begin
            $display("CHECK FAILED out_item.rd: expected %h got %h", head.rd, out_item.rd);
            err_count++;
          end
          if (out_item.data !== want) begin
            $display("CHECK FAILED out_item.data: expected %h got %h (op %h a %h b %h)",
                     want, out_item.data, head.op, head.a, head.b);
            err_count++;
          end
          done_count++;
        end
      end
      if (in_valid && in_ready) expect_q.push_back(in_item);
      stalled = out_valid && !out_ready;
      last_item = out_item;
    end
    if (reset) begin
      idle_since_reset = 1'b1;
    end else if (in_valid && in_ready) begin
      idle_since_reset = 1'b0;
    end
    q_size = expect_q.size();
  end

endmodule

// ==== test/exu_tb.sv ====
`timescale 1ns/1ps

module exu_tb;

  localparam int ITEMS = 400;
  localparam int PHASE_ITEMS = 100;
  localparam int PERIOD = 4;
  localparam int CYCLES_PER_ITEM = 40;
  localparam int LIMIT_NS = ITEMS * CYCLES_PER_ITEM * PERIOD * 3;

  logic                 clock;
  logic                 reset;
  logic                 flush;
  logic                 in_valid;
  logic                 in_ready;
  exu_bus_pkg::issue_t  in_item;
  logic                 out_valid;
  logic                 out_ready;
  exu_bus_pkg::result_t out_item;
  int                   errors;
  int                   pending;
  int                   checked;
  int                   phase;
  logic                 accepted;
  logic [31:0]          next_pc;

  exu_top DUT (
    .clock(clock), .reset(reset), .flush(flush),
    .in_valid(in_valid), .in_ready(in_ready), .in_item(in_item),
    .out_valid(out_valid), .out_ready(out_ready), .out_item(out_item)
  );

  exu_checker u_checker (
    .clock(clock), .reset(reset), .flush(flush),
    .in_valid(in_valid), .in_ready(in_ready), .in_item(in_item),
    .out_valid(out_valid), .out_ready(out_ready), .out_item(out_item),
    .errors(errors), .pending(pending), .checked(checked)
  );

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  initial begin
    #(LIMIT_NS);
    $display("Timeout: the run did not finish within %0d ns", LIMIT_NS);
    $display("FAIL: see errors above");
    $finish;
  end

  // Corner values show up far more often than uniform
  function automatic logic [31:0] pick_operand();
    case ($urandom % 6)
      0: return 32'h0000_0000;
      1: return 32'hffff_ffff;
      2: return 32'h8000_0000;
      default: return $urandom;
    endcase
  endfunction

  function automatic exu_bus_pkg::issue_t random_item(int sel, logic [31:0] pc);
    exu_bus_pkg::issue_t item;
    int unsigned         code;
    case (sel)
      0: code = $urandom % 10;
      1: code = 10 + $urandom % 4;
      2: code = 14 + $urandom % 4;
      default: code = $urandom % 18;
    endcase
    item.pc = pc;
    item.op = exu_op_pkg::op_e'(code[4:0]);
    item.a = pick_operand();
    item.b = pick_operand();
    item.rd = 5'($urandom);
    return item;
  endfunction

  // One clock, then new back-pressure and flush at the falling edge
  task automatic step_cycle();
    @(posedge clock);
    accepted = in_valid && in_ready;
    @(negedge clock);
    if (phase == 3) begin
      out_ready = ($urandom % 10) >= 3;
      flush = !flush && ($urandom % 40 == 0);
    end else begin
      out_ready = 1'b1;
      flush = 1'b0;
    end
  endtask

  task automatic send_item(input exu_bus_pkg::issue_t item);
    in_valid = 1'b1;
    in_item = item;
    accepted = 1'b0;
    while (!accepted) step_cycle();
    in_valid = 1'b0;
  endtask

  initial begin
    int p;
    int i;
    void'($urandom(32'h78a1));
    reset = 1'b1;
    flush = 1'b0;
    in_valid = 1'b0;
    in_item = '0;
    out_ready = 1'b1;
    phase = 0;
    accepted = 1'b0;
    next_pc = 32'h0000_1000;
    repeat (8) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    // ALU, multiply, divide, then everything mixed
    for (p = 0; p < 4; p++) begin
      phase = p;
      for (i = 0; i < PHASE_ITEMS; i++) begin
        if ($urandom % 4 == 0) step_cycle();
        send_item(random_item(p, next_pc));
        next_pc = next_pc + 32'd4;
      end
    end
    phase = 4;
    while (pending != 0 || out_valid) step_cycle();
    repeat (4) step_cycle();
    $display("Run complete: %0d results checked, %0d errors", checked, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
source/exu_op_pkg.sv
source/exu_bus_pkg.sv
source/exu_issue.sv
source/exu_alu.sv
source/exu_mul.sv
source/exu_div.sv
source/exu_writeback.sv
source/exu_top.sv
test/exu_checker.sv
test/exu_tb.sv
